// File: common/cpuPkg.sv
// Shared encodings for the 32-bit load/store CPU with both RAMs fixed at 256 words and no branches
package cpuPkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 8;   // 256-word RAMs
  localparam int REG_SEL_W = 4;   // Sixteen registers
  localparam int SHAMT_W   = 5;
  localparam int IMM_W     = 16;
  localparam int FLAG_W    = 4;
  localparam int OP_W      = 4;
  localparam int COND_W    = 4;

  // Flag bit positions in the flag vector, ordered N Z C V from the top
  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // Instruction field LSBs
  localparam int COND_LSB  = 28;
  localparam int OP_LSB    = 24;
  localparam int S_BIT     = 23;  // Flag update request
  localparam int DST_LSB   = 19;
  localparam int SRC2_LSB  = 15;
  localparam int SRC1_LSB  = 11;
  localparam int SHAMT_LSB = 6;
  localparam int IMM_LSB   = 3;   // Overlaps src2, src1 and shamt

  typedef enum logic [OP_W-1:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ORR, OP_MOV, OP_CMP,
    OP_LSL, OP_LSR, OP_ROR, OP_MOVI,
    OP_LDR, OP_STR, OP_NOP, OP_HALT
  } opcodeT;

  // ARM style condition codes
  typedef enum logic [COND_W-1:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condT;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEMRD,   // LDR only
    ST_WRITE,
    ST_HALT
  } cpuStateT;

endpackage

// File: alu/masterAlu.sv
// Purely combinational; C and V are only produced by ADD, SUB, RSB and CMP and pass through otherwise
`timescale 1ns/1ps

module masterAlu import cpuPkg::*; (
  input  opcodeT              opcode_i,
  input  logic [DATA_W-1:0]   opA_i,     // Source 1
  input  logic [DATA_W-1:0]   opB_i,     // Source 2
  input  logic [SHAMT_W-1:0]  shamt_i,
  input  logic [IMM_W-1:0]    imm_i,
  input  logic [FLAG_W-1:0]   flags_i,   // Current flag register
  output logic [DATA_W-1:0]   result_o,
  output logic [FLAG_W-1:0]   flags_o
);

  logic [DATA_W-1:0]   addA;
  logic [DATA_W-1:0]   addB;
  logic                addCin;
  logic [DATA_W:0]     addSum;     // Carry in the top bit
  logic [2*DATA_W-1:0] rorWide;
  logic [ADDR_W-1:0]   effAddr;
  logic                arith;      // Op drives C and V

  // Shared adder, subtraction as A + ~B + 1
  always_comb
  begin
    addA   = opA_i;
    addB   = opB_i;
    addCin = 1'b0;
    unique case (opcode_i)
      OP_SUB, OP_CMP:
      begin
        addB   = ~opB_i;
        addCin = 1'b1;
      end
      OP_RSB:
      begin
        addA   = opB_i;              // Reverse subtract B - A
        addB   = ~opA_i;
        addCin = 1'b1;
      end
      default: ;
    endcase
  end

  assign addSum  = {1'b0, addA} + {1'b0, addB} + {{DATA_W{1'b0}}, addCin};
  assign rorWide = {opA_i, opA_i} >> shamt_i;       // Rotate via doubled word
  assign effAddr = opA_i[ADDR_W-1:0] + ADDR_W'(shamt_i); // Wraps mod 256

  always_comb
  begin
    arith = 1'b0;
    unique case (opcode_i)
      OP_AND:                 result_o = opA_i & opB_i;
      OP_EOR:                 result_o = opA_i ^ opB_i;
      OP_ORR:                 result_o = opA_i | opB_i;
      OP_MOV:                 result_o = opB_i;     // Operand 2 copy
      OP_ADD, OP_SUB, OP_RSB, OP_CMP:
      begin
        result_o = addSum[DATA_W-1:0];
        arith    = 1'b1;
      end
      OP_LSL:                 result_o = opA_i << shamt_i;
      OP_LSR:                 result_o = opA_i >> shamt_i;  // Logical, zero fill
      OP_ROR:                 result_o = rorWide[DATA_W-1:0];
      OP_MOVI:                result_o = {{(DATA_W-IMM_W){1'b0}}, imm_i};
      OP_LDR, OP_STR:         result_o = {{(DATA_W-ADDR_W){1'b0}}, effAddr};
      default:                result_o = '0;        // NOP and HALT
    endcase
  end

  always_comb
  begin
    flags_o         = flags_i;
    flags_o[FLAG_N] = result_o[DATA_W-1];
    flags_o[FLAG_Z] = (result_o == '0);
    if (arith)
    begin
      flags_o[FLAG_C] = addSum[DATA_W];   // Not-borrow on subtract
      // Overflow when same-sign operands give a result of the other sign
      flags_o[FLAG_V] = (addA[DATA_W-1] == addB[DATA_W-1]) &&
                        (addSum[DATA_W-1] != addA[DATA_W-1]);
    end
  end

endmodule

// File: design/registerBank.sv
// Sixteen general registers with no PC alias; reads are combinational and r0 is writable
`timescale 1ns/1ps

module registerBank import cpuPkg::*; (
  input  logic                 Clk,
  input  logic                 rst_i,
  input  logic                 we_i,
  input  logic [REG_SEL_W-1:0] wSel_i,
  input  logic [DATA_W-1:0]    wData_i,
  input  logic [REG_SEL_W-1:0] rSel1_i,
  input  logic [REG_SEL_W-1:0] rSel2_i,
  output logic [DATA_W-1:0]    rData1_o,
  output logic [DATA_W-1:0]    rData2_o
);

  logic [DATA_W-1:0] regs [2**REG_SEL_W];

  always_ff @(posedge Clk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < 2**REG_SEL_W; i++)
        regs[i] <= '0;   // Whole bank cleared
    end
    else if (we_i)
    begin
      regs[wSel_i] <= wData_i;
    end
  end

  // Write lands next edge, so a same-cycle read still sees the old value
  assign rData1_o = regs[rSel1_i];
  assign rData2_o = regs[rSel2_i];

  // Unknown select would corrupt an arbitrary register
  wSelKnown: assert property (@(posedge Clk) disable iff (rst_i)
    we_i |-> !$isunknown(wSel_i))
    else $error("registerBank write with unknown select %h", wSel_i);

endmodule

// File: design/wordRam.sv
// Single-port 256x32 RAM with registered read and no reset of its contents
`timescale 1ns/1ps

module wordRam import cpuPkg::*; (
  input  logic              Clk,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wData_i,
  output logic [DATA_W-1:0] rData_o
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge Clk)
  begin
    if (we_i)
    begin
      mem[addr_i] <= wData_i;
    end
    rData_o <= mem[addr_i];  // Old data on a write cycle
  end

endmodule

// File: memctrl/memoryControl.sv
// Host requests are served only while the CPU is idle or halted, and host fields must stay stable until ack
`timescale 1ns/1ps

module memoryControl import cpuPkg::*; (
  input  logic              Clk,
  input  logic              rst_i,
  input  logic              cpuBusy_i,
  input  logic              memRd_i,
  input  logic              memWr_i,
  input  logic [ADDR_W-1:0] cpuAddr_i,
  input  logic [DATA_W-1:0] cpuWData_i,
  input  logic              fetchEn_i,
  input  logic [ADDR_W-1:0] pc_i,
  input  logic              hostReq_i,
  input  logic              hostWrite_i,
  input  logic              hostInstrSel_i,  // 1 selects instruction RAM
  input  logic [ADDR_W-1:0] hostAddr_i,
  input  logic [DATA_W-1:0] hostWData_i,
  input  logic [DATA_W-1:0] dataRamRData_i,
  input  logic [DATA_W-1:0] instrRamRData_i,
  output logic              hostAck_o,
  output logic [DATA_W-1:0] hostRData_o,
  output logic              dataRamWe_o,
  output logic [ADDR_W-1:0] dataRamAddr_o,
  output logic [DATA_W-1:0] dataRamWData_o,
  output logic              instrRamWe_o,
  output logic [ADDR_W-1:0] instrRamAddr_o,
  output logic [DATA_W-1:0] instrRamWData_o
);

  typedef enum logic [1:0] {
    H_IDLE,
    H_RDWAIT,   // RAM read latency
    H_ACK
  } hostStateT;

  hostStateT         hState;
  hostStateT         hNext;
  logic              hostGrant;   // Request accepted this cycle
  logic              hostWrStb;
  logic              cpuAccess;
  logic [DATA_W-1:0] rDataHold;

  assign hostGrant = (hState == H_IDLE) && hostReq_i && !cpuBusy_i;
  assign hostWrStb = hostGrant && hostWrite_i;
  assign cpuAccess = memRd_i || memWr_i;

  // Data RAM owned by the CPU only during its own load/store cycles
  assign dataRamAddr_o  = cpuAccess ? cpuAddr_i : hostAddr_i;
  assign dataRamWData_o = cpuAccess ? cpuWData_i : hostWData_i;
  assign dataRamWe_o    = memWr_i || (hostWrStb && !hostInstrSel_i);

  // Instruction RAM follows the PC while fetching
  assign instrRamAddr_o  = fetchEn_i ? pc_i : hostAddr_i;
  assign instrRamWData_o = hostWData_i;
  assign instrRamWe_o    = hostWrStb && hostInstrSel_i && !fetchEn_i;

  assign hostAck_o   = (hState == H_ACK);
  assign hostRData_o = rDataHold;  // Held for the whole ack phase

  always_comb
  begin
    hNext = hState;
    unique case (hState)
      H_IDLE:   if (hostGrant) hNext = hostWrite_i ? H_ACK : H_RDWAIT;
      H_RDWAIT: hNext = H_ACK;
      H_ACK:    if (!hostReq_i) hNext = H_IDLE;  // Ack drops a cycle after req
      default:  hNext = H_IDLE;
    endcase
  end

  always_ff @(posedge Clk)
  begin
    if (rst_i)
      hState <= H_IDLE;
    else
      hState <= hNext;
  end

  always_ff @(posedge Clk)
  begin
    if (hState == H_RDWAIT)
      rDataHold <= hostInstrSel_i ? instrRamRData_i : dataRamRData_i;
  end

  // Host never sees an ack while the controller runs a program
  ackNotBusy: assert property (@(posedge Clk) disable iff (rst_i)
    $rose(hostAck_o) |-> !cpuBusy_i)
    else $error("memoryControl ack raised while CPU busy");

endmodule

// File: design/controlUnit.sv
// One instruction in flight and no branches, so the PC only counts up; HALT holds until the next run pulse
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
  input  logic                 Clk,
  input  logic                 rst_i,
  input  logic                 run_i,
  input  logic [DATA_W-1:0]    instr_i,      // Instruction RAM read data
  input  logic [FLAG_W-1:0]    aluFlags_i,
  output logic [ADDR_W-1:0]    pc_o,
  output logic                 fetchEn_o,
  output logic [FLAG_W-1:0]    flags_o,
  output logic                 regWe_o,
  output logic [REG_SEL_W-1:0] regWSel_o,
  output logic                 wbFromMem_o,
  output logic                 memRd_o,
  output logic                 memWr_o,
  output logic                 busy_o,
  output logic                 halted_o,
  output opcodeT               opcode_o,
  output logic [REG_SEL_W-1:0] rSel1_o,
  output logic [REG_SEL_W-1:0] rSel2_o,
  output logic [SHAMT_W-1:0]   shamt_o,
  output logic [IMM_W-1:0]     imm_o
);

  cpuStateT          state;
  cpuStateT          nextState;
  logic [DATA_W-1:0] instrReg;
  logic [DATA_W-1:0] curInstr;
  logic [FLAG_W-1:0] flagReg;
  condT              cond;
  logic              condPass;
  logic              aluOp;        // Plain ALU ops, S bit decides flags
  logic              writesReg;
  logic              setsFlags;

  // RAM data is live in EXEC, the latched copy afterwards
  assign curInstr  = (state == ST_EXEC) ? instr_i : instrReg;
  assign cond      = condT'(curInstr[COND_LSB +: COND_W]);
  assign opcode_o  = opcodeT'(curInstr[OP_LSB +: OP_W]);
  assign regWSel_o = curInstr[DST_LSB +: REG_SEL_W];
  assign rSel2_o   = curInstr[SRC2_LSB +: REG_SEL_W];
  assign rSel1_o   = curInstr[SRC1_LSB +: REG_SEL_W];
  assign shamt_o   = curInstr[SHAMT_LSB +: SHAMT_W];
  assign imm_o     = curInstr[IMM_LSB +: IMM_W];

  always_comb
  begin
    unique case (cond)
      EQ: condPass = flagReg[FLAG_Z];
      NE: condPass = !flagReg[FLAG_Z];
      CS: condPass = flagReg[FLAG_C];
      CC: condPass = !flagReg[FLAG_C];
      MI: condPass = flagReg[FLAG_N];
      PL: condPass = !flagReg[FLAG_N];
      VS: condPass = flagReg[FLAG_V];
      VC: condPass = !flagReg[FLAG_V];
      HI: condPass = flagReg[FLAG_C] && !flagReg[FLAG_Z];
      LS: condPass = !flagReg[FLAG_C] || flagReg[FLAG_Z];
      GE: condPass = (flagReg[FLAG_N] == flagReg[FLAG_V]);
      LT: condPass = (flagReg[FLAG_N] != flagReg[FLAG_V]);
      GT: condPass = !flagReg[FLAG_Z] && (flagReg[FLAG_N] == flagReg[FLAG_V]);
      LE: condPass = flagReg[FLAG_Z] || (flagReg[FLAG_N] != flagReg[FLAG_V]);
      AL: condPass = 1'b1;
      default: condPass = 1'b0;   // NV never executes
    endcase
  end

  assign aluOp     = (opcode_o <= OP_ROR && opcode_o != OP_CMP) || opcode_o == OP_MOVI;
  assign writesReg = aluOp || opcode_o == OP_LDR;
  assign setsFlags = opcode_o == OP_CMP || (aluOp && curInstr[S_BIT]);

  // Commits happen only in WRITE, and a failed condition leaves a no-op
  assign regWe_o     = (state == ST_WRITE) && condPass && writesReg;
  assign wbFromMem_o = (opcode_o == OP_LDR);
  assign memRd_o     = (state == ST_MEMRD);
  assign memWr_o     = (state == ST_WRITE) && condPass && opcode_o == OP_STR;
  assign fetchEn_o   = (state == ST_FETCH);
  assign busy_o      = (state != ST_IDLE) && (state != ST_HALT);
  assign halted_o    = (state == ST_HALT);
  assign flags_o     = flagReg;

  always_comb
  begin
    nextState = state;
    unique case (state)
      ST_IDLE, ST_HALT: if (run_i) nextState = ST_FETCH;
      ST_FETCH:         nextState = ST_EXEC;
      ST_EXEC:
      begin
        if (!condPass)                nextState = ST_WRITE;
        else if (opcode_o == OP_HALT) nextState = ST_HALT;
        else if (opcode_o == OP_LDR)  nextState = ST_MEMRD;  // Extra read cycle
        else                          nextState = ST_WRITE;
      end
      ST_MEMRD:         nextState = ST_WRITE;
      ST_WRITE:         nextState = ST_FETCH;
      default:          nextState = ST_IDLE;
    endcase
  end

  always_ff @(posedge Clk)
  begin
    if (rst_i)
    begin
      state   <= ST_IDLE;
      pc_o    <= '0;
      flagReg <= '0;
    end
    else
    begin
      state <= nextState;
      if ((state == ST_IDLE || state == ST_HALT) && run_i)
        pc_o <= '0;                 // Every run starts at word 0
      else if (state == ST_WRITE)
        pc_o <= pc_o + 1'b1;
      if (state == ST_WRITE && condPass && setsFlags)
        flagReg <= aluFlags_i;
    end
  end

  always_ff @(posedge Clk)
  begin
    if (state == ST_EXEC)
      instrReg <= instr_i;
  end

  // Read cycle must still decode the latched load
  loadCycleIsLdr: assert property (@(posedge Clk) disable iff (rst_i)
    memRd_o |-> (opcode_o == OP_LDR))
    else $error("controlUnit data read cycle without a latched LDR");

  stateKnown: assert property (@(posedge Clk) disable iff (rst_i)
    !$isunknown(state))
    else $error("controlUnit state unknown after reset");

endmodule

// File: design/masterCpu.sv
// Top level of the multicycle CPU; program load and data readback go only through the host req/ack port
`timescale 1ns/1ps

module masterCpu import cpuPkg::*; (
  input  logic              Clk,
  input  logic              rst_i,
  input  logic              run_i,
  output logic              halted_o,
  input  logic              hostReq_i,
  input  logic              hostWrite_i,
  input  logic              hostInstrSel_i,
  input  logic [ADDR_W-1:0] hostAddr_i,
  input  logic [DATA_W-1:0] hostWData_i,
  output logic              hostAck_o,
  output logic [DATA_W-1:0] hostRData_o
);

  logic [ADDR_W-1:0]    instrRamAddr;
  logic [DATA_W-1:0]    instrRamWData;
  logic [DATA_W-1:0]    instrRamRData;
  logic                 instrRamWe;
  logic [ADDR_W-1:0]    dataRamAddr;
  logic [DATA_W-1:0]    dataRamWData;
  logic [DATA_W-1:0]    dataRamRData;
  logic                 dataRamWe;
  logic [DATA_W-1:0]    rData1;
  logic [DATA_W-1:0]    rData2;    // Also the STR data
  logic [DATA_W-1:0]    wbData;
  logic [DATA_W-1:0]    aluResult;
  logic [FLAG_W-1:0]    aluFlags;
  logic [FLAG_W-1:0]    flags;
  logic [ADDR_W-1:0]    pc;
  logic                 fetchEn;
  logic                 regWe;
  logic [REG_SEL_W-1:0] regWSel;
  logic                 wbFromMem;
  logic                 memRd;
  logic                 memWr;
  logic                 cpuBusy;
  opcodeT               opcode;
  logic [REG_SEL_W-1:0] rSel1;
  logic [REG_SEL_W-1:0] rSel2;
  logic [SHAMT_W-1:0]   shamt;
  logic [IMM_W-1:0]     imm;

  assign wbData = wbFromMem ? dataRamRData : aluResult;  // LDR takes RAM data

  wordRam u_instrRam (.Clk(Clk), .we_i(instrRamWe), .addr_i(instrRamAddr),
                      .wData_i(instrRamWData), .rData_o(instrRamRData));

  wordRam u_dataRam (.Clk(Clk), .we_i(dataRamWe), .addr_i(dataRamAddr),
                     .wData_i(dataRamWData), .rData_o(dataRamRData));

  registerBank u_regBank (.Clk(Clk), .rst_i(rst_i), .we_i(regWe), .wSel_i(regWSel),
                          .wData_i(wbData), .rSel1_i(rSel1), .rSel2_i(rSel2),
                          .rData1_o(rData1), .rData2_o(rData2));

  masterAlu u_alu (.opcode_i(opcode), .opA_i(rData1), .opB_i(rData2), .shamt_i(shamt),
                   .imm_i(imm), .flags_i(flags), .result_o(aluResult), .flags_o(aluFlags));

  controlUnit u_ctrl (.Clk(Clk), .rst_i(rst_i), .run_i(run_i), .instr_i(instrRamRData),
                      .aluFlags_i(aluFlags), .pc_o(pc), .fetchEn_o(fetchEn), .flags_o(flags),
                      .regWe_o(regWe), .regWSel_o(regWSel), .wbFromMem_o(wbFromMem),
                      .memRd_o(memRd), .memWr_o(memWr), .busy_o(cpuBusy),
                      .halted_o(halted_o), .opcode_o(opcode), .rSel1_o(rSel1),
                      .rSel2_o(rSel2), .shamt_o(shamt), .imm_o(imm));

  memoryControl u_memCtrl (.Clk(Clk), .rst_i(rst_i), .cpuBusy_i(cpuBusy), .memRd_i(memRd),
                           .memWr_i(memWr), .cpuAddr_i(aluResult[ADDR_W-1:0]),
                           .cpuWData_i(rData2), .fetchEn_i(fetchEn), .pc_i(pc),
                           .hostReq_i(hostReq_i), .hostWrite_i(hostWrite_i),
                           .hostInstrSel_i(hostInstrSel_i), .hostAddr_i(hostAddr_i),
                           .hostWData_i(hostWData_i), .dataRamRData_i(dataRamRData),
                           .instrRamRData_i(instrRamRData), .hostAck_o(hostAck_o),
                           .hostRData_o(hostRData_o), .dataRamWe_o(dataRamWe),
                           .dataRamAddr_o(dataRamAddr), .dataRamWData_o(dataRamWData),
                           .instrRamWe_o(instrRamWe), .instrRamAddr_o(instrRamAddr),
                           .instrRamWData_o(instrRamWData));

endmodule

// File: dv/tbMasterCpu.sv
// Self-checking bench; programs must fit the 256-word instruction RAM and each one ends in HALT
`timescale 1ns/1ps

module tbMasterCpu import cpuPkg::*; ();

  localparam int HALF_NS     = 2;                 // 4 ns clock
  localparam int NUM_TESTS   = 6;
  localparam int MAX_PROG    = 256;
  localparam int HOST_CYC    = 6;                 // Worst host transfer
  localparam int WATCHDOG_NS = NUM_TESTS * MAX_PROG * (4 + 2 * HOST_CYC) * 2 * HALF_NS + 2000;

  logic              Clk = 1'b0;
  logic              rst_i;
  logic              run_i;
  logic              halted_o;
  logic              hostReq_i;
  logic              hostWrite_i;
  logic              hostInstrSel_i;
  logic [ADDR_W-1:0] hostAddr_i;
  logic [DATA_W-1:0] hostWData_i;
  logic              hostAck_o;
  logic [DATA_W-1:0] hostRData_o;

  // Reference model state
  logic [DATA_W-1:0] mRegs [16];
  logic [DATA_W-1:0] mData [256];
  logic              mN, mZ, mC, mV;

  logic [DATA_W-1:0] prog [$];
  logic [ADDR_W-1:0] chkAddr [$];   // Data words read back after a run
  logic [DATA_W-1:0] expRData;
  logic              progActive;
  string             curTest;
  int                errCount;
  int                errAtStart;
  int                testCount;
  int                checkCount;
  opcodeT            aluOps [7] = '{OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ORR, OP_MOV};
  opcodeT            shiftOps [3] = '{OP_LSL, OP_LSR, OP_ROR};

  always #HALF_NS Clk = ~Clk;

  masterCpu u_masterCpu (.Clk(Clk), .rst_i(rst_i), .run_i(run_i), .halted_o(halted_o),
                         .hostReq_i(hostReq_i), .hostWrite_i(hostWrite_i),
                         .hostInstrSel_i(hostInstrSel_i), .hostAddr_i(hostAddr_i),
                         .hostWData_i(hostWData_i), .hostAck_o(hostAck_o),
                         .hostRData_o(hostRData_o));

  ackLowAfterReset: assert property (@(posedge Clk) $fell(rst_i) |-> !hostAck_o)
    else
    begin
      errCount++;
      $display("%s: host ack was high right after reset", curTest);
    end

  ackNeedsReq: assert property (@(posedge Clk) disable iff (rst_i)
    $rose(hostAck_o) |-> hostReq_i)
    else
    begin
      errCount++;
      $display("%s: host ack rose with no request pending", curTest);
    end

  // Four-phase release, ack follows req down one cycle later
  ackDropsAfterReq: assert property (@(posedge Clk) disable iff (rst_i)
    (hostAck_o && !hostReq_i) |=> !hostAck_o)
    else
    begin
      errCount++;
      $display("%s: host ack stayed high after request dropped", curTest);
    end

  writeAckTiming: assert property (@(posedge Clk) disable iff (rst_i)
    ($rose(hostReq_i) && hostWrite_i && !progActive) |=> hostAck_o)
    else
    begin
      errCount++;
      $display("%s: idle write not acked one cycle after request", curTest);
    end

  readAckTiming: assert property (@(posedge Clk) disable iff (rst_i)
    ($rose(hostReq_i) && !hostWrite_i && !progActive) |=> !hostAck_o ##1 hostAck_o)
    else
    begin
      errCount++;
      $display("%s: idle read not acked two cycles after request", curTest);
    end

  readData: assert property (@(posedge Clk) disable iff (rst_i)
    ($rose(hostAck_o) && !hostWrite_i) |-> hostRData_o == expRData)
    else
    begin
      errCount++;
      $display("Error %s: expected %h, actual %h", curTest, expRData, $sampled(hostRData_o));
    end

  ackWaitsForHalt: assert property (@(posedge Clk) disable iff (rst_i)
    $rose(hostAck_o) |-> (!progActive || halted_o))
    else
    begin
      errCount++;
      $display("%s: host ack granted while the program was still running", curTest);
    end

  haltHolds: assert property (@(posedge Clk) disable iff (rst_i)
    (halted_o && !run_i) |=> halted_o)
    else
    begin
      errCount++;
      $display("%s: halted dropped without a run pulse", curTest);
    end

  function automatic logic [DATA_W-1:0] regInstr(input condT c, input opcodeT op,
                                                 input logic s, input logic [3:0] rd,
                                                 input logic [3:0] rs2, input logic [3:0] rs1,
                                                 input logic [4:0] sh);
    return {c, op, s, rd, rs2, rs1, sh, 6'b0};
  endfunction

  function automatic logic [DATA_W-1:0] immInstr(input condT c, input logic [3:0] rd,
                                                 input logic [15:0] imm, input logic s);
    return {c, OP_MOVI, s, rd, imm, 3'b0};
  endfunction

  // ARM condition table over the model flags
  function automatic logic condHolds(input logic [3:0] c);
    case (condT'(c))
      EQ: return mZ;
      NE: return !mZ;
      CS: return mC;
      CC: return !mC;
      MI: return mN;
      PL: return !mN;
      VS: return mV;
      VC: return !mV;
      HI: return mC && !mZ;
      LS: return !mC || mZ;
      GE: return mN == mV;
      LT: return mN != mV;
      GT: return !mZ && (mN == mV);
      LE: return mZ || (mN != mV);
      AL: return 1'b1;
      default: return 1'b0;   // NV
    endcase
  endfunction

  function automatic void modelStep(input logic [DATA_W-1:0] ins);
    opcodeT            op;
    logic [3:0]        rd;
    logic [4:0]        sh;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] r;
    logic [DATA_W:0]   wide;
    logic [7:0]        ea;
    logic              arith;
    logic              c;
    logic              v;
    op    = opcodeT'(ins[OP_LSB +: 4]);
    rd    = ins[DST_LSB +: 4];
    sh    = ins[SHAMT_LSB +: 5];
    a     = mRegs[ins[SRC1_LSB +: 4]];
    b     = mRegs[ins[SRC2_LSB +: 4]];
    ea    = 8'(a[7:0] + sh);            // Wraps mod 256
    arith = 1'b0;
    c     = mC;
    v     = mV;
    r     = '0;
    if (!condHolds(ins[COND_LSB +: 4]) || op == OP_NOP || op == OP_HALT)
      return;
    case (op)
      OP_AND: r = a & b;
      OP_EOR: r = a ^ b;
      OP_ORR: r = a | b;
      OP_MOV: r = b;
      OP_ADD:
      begin
        wide  = {1'b0, a} + {1'b0, b};
        r     = wide[DATA_W-1:0];
        c     = wide[DATA_W];
        v     = (a[31] == b[31]) && (r[31] != a[31]);
        arith = 1'b1;
      end
      OP_SUB, OP_CMP:
      begin
        r     = a - b;
        c     = a >= b;                 // No borrow
        v     = (a[31] != b[31]) && (r[31] != a[31]);
        arith = 1'b1;
      end
      OP_RSB:
      begin
        r     = b - a;
        c     = b >= a;
        v     = (a[31] != b[31]) && (r[31] != b[31]);
        arith = 1'b1;
      end
      OP_LSL:  r = a << sh;
      OP_LSR:  r = a >> sh;
      OP_ROR:  r = (a >> sh) | (a << (32 - int'(sh)));
      OP_MOVI: r = {16'b0, ins[IMM_LSB +: 16]};
      OP_LDR:
      begin
        mRegs[rd] = mData[ea];
        return;
      end
      OP_STR:
      begin
        mData[ea] = b;
        return;
      end
      default: ;
    endcase
    if (op != OP_CMP)
      mRegs[rd] = r;
    if (op == OP_CMP || ins[S_BIT])
    begin
      mN = r[31];
      mZ = (r == '0);
      if (arith)
      begin
        mC = c;
        mV = v;
      end
    end
  endfunction

  task automatic hostWrite(input logic instrSel, input logic [7:0] addr,
                           input logic [DATA_W-1:0] data);
    if (!instrSel)
      mData[addr] = data;   // Mirror data RAM
    @(posedge Clk);
    hostReq_i      <= 1'b1;
    hostWrite_i    <= 1'b1;
    hostInstrSel_i <= instrSel;
    hostAddr_i     <= addr;
    hostWData_i    <= data;
    do
      @(posedge Clk);
    while (!hostAck_o);
    hostReq_i <= 1'b0;
    do
      @(posedge Clk);
    while (hostAck_o);      // Ack low before the next request
  endtask

  task automatic hostRead(input logic instrSel, input logic [7:0] addr,
                          input logic [DATA_W-1:0] expected);
    expRData = expected;
    checkCount++;
    @(posedge Clk);
    hostReq_i      <= 1'b1;
    hostWrite_i    <= 1'b0;
    hostInstrSel_i <= instrSel;
    hostAddr_i     <= addr;
    do
      @(posedge Clk);
    while (!hostAck_o);
    hostReq_i <= 1'b0;
    do
      @(posedge Clk);
    while (hostAck_o);
  endtask

  task automatic runProgram();
    @(posedge Clk);
    run_i      <= 1'b1;
    progActive = 1'b1;
    @(posedge Clk);
    run_i <= 1'b0;
    do
      @(posedge Clk);
    while (!halted_o);
    progActive = 1'b0;
  endtask

  // Base in r15, then every register to base + index
  task automatic storeAllRegs(input logic [7:0] base);
    prog.push_back(immInstr(AL, 15, {8'b0, base}, 1'b0));
    for (int k = 0; k < 16; k++)
    begin
      prog.push_back(regInstr(AL, OP_STR, 1'b0, 0, k, 15, k));
      chkAddr.push_back(8'(base + k));
    end
  endtask

  task automatic loadProgram();
    foreach (prog[i])
      hostWrite(1'b1, 8'(i), prog[i]);
    foreach (prog[i])
      modelStep(prog[i]);
  endtask

  task automatic startTest(input string name);
    curTest    = name;
    errAtStart = errCount;
    prog.delete();
    chkAddr.delete();
  endtask

  task automatic finishTest();
    testCount++;
    $display("%-14s %s (%0d errors)", curTest,
             (errCount == errAtStart) ? "ok" : "FAILED", errCount - errAtStart);
  endtask

  task automatic haltRunCheck();
    prog.push_back(regInstr(AL, OP_HALT, 1'b0, 0, 0, 0, 0));
    loadProgram();
    runProgram();
    foreach (chkAddr[i])
      hostRead(1'b0, chkAddr[i], mData[chkAddr[i]]);
    finishTest();
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns, a handshake or halt never arrived", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    logic [7:0] addr;
    void'($urandom(85));
    rst_i          = 1'b1;
    run_i          = 1'b0;
    hostReq_i      = 1'b0;
    hostWrite_i    = 1'b0;
    hostInstrSel_i = 1'b0;
    hostAddr_i     = '0;
    hostWData_i    = '0;
    progActive     = 1'b0;
    {mN, mZ, mC, mV} = 4'b0;
    foreach (mRegs[i])
      mRegs[i] = '0;
    repeat (2) @(posedge Clk);
    rst_i <= 1'b0;

    // Fill whole data RAM, then spot-read it
    startTest("hostRoundTrip");
    for (int i = 0; i < 256; i++)
      hostWrite(1'b0, 8'(i), $urandom);
    for (int i = 0; i < 64; i++)
    begin
      addr = 8'($urandom);
      hostRead(1'b0, addr, mData[addr]);
    end
    finishTest();

    startTest("aluRegs");
    for (int i = 0; i < 16; i++)
      prog.push_back(immInstr(AL, i, 16'($urandom), 1'($urandom)));
    for (int i = 0; i < 24; i++)
      prog.push_back(regInstr(AL, aluOps[$urandom % 7], 1'($urandom), 4'($urandom),
                              4'($urandom), 4'($urandom), 0));
    storeAllRegs(8'h40);
    haltRunCheck();

    // Full-width operands from two MOVI halves
    startTest("shiftImm");
    for (int i = 1; i <= 4; i++)
    begin
      prog.push_back(immInstr(AL, i, 16'($urandom), 1'b0));
      prog.push_back(regInstr(AL, OP_LSL, 1'b0, i, 0, i, 16));
      prog.push_back(immInstr(AL, 5, 16'($urandom), 1'b0));
      prog.push_back(regInstr(AL, OP_ORR, 1'b0, i, 5, i, 0));
    end
    for (int i = 0; i < 12; i++)
      prog.push_back(regInstr(AL, shiftOps[$urandom % 3], 1'($urandom), 6 + i % 9, 0,
                              1 + $urandom % 4, 5'($urandom)));
    storeAllRegs(8'h60);
    haltRunCheck();

    // Pairs: random, equal, signed overflow
    startTest("flagsCond");
    for (int p = 0; p < 3; p++)
    begin
      prog.push_back(immInstr(AL, 1, (p == 2) ? 16'h7fff : 16'($urandom), 1'b0));
      prog.push_back(regInstr(AL, OP_LSL, 1'b0, 1, 0, 1, 16));
      prog.push_back(immInstr(AL, 2, (p == 2) ? 16'h8000 : 16'($urandom), 1'b0));
      prog.push_back(regInstr(AL, OP_LSL, 1'b0, 2, 0, 2, 16));
      if (p == 1)
        prog.push_back(regInstr(AL, OP_MOV, 1'b0, 2, 1, 0, 0));   // r2 = r1
      prog.push_back(regInstr(AL, OP_CMP, 1'b0, 0, 2, 1, 0));
      prog.push_back(immInstr(AL, 15, 16'(8'hA0 + 16 * p), 1'b0));
      for (int c = 0; c < 16; c++)
      begin
        prog.push_back(immInstr(AL, 3, 16'h0, 1'b0));
        prog.push_back(immInstr(condT'(c), 3, 16'(c + 1), 1'b0));
        prog.push_back(regInstr(AL, OP_STR, 1'b0, 0, 3, 15, c));
        chkAddr.push_back(8'(8'hA0 + 16 * p + c));
      end
    end
    // V still set after ADD without S
    prog.push_back(immInstr(AL, 3, 16'h0, 1'b0));
    prog.push_back(regInstr(AL, OP_ADD, 1'b0, 5, 2, 1, 0));
    prog.push_back(immInstr(VS, 3, 16'h55, 1'b0));
    prog.push_back(regInstr(AL, OP_STR, 1'b0, 0, 3, 15, 31));
    chkAddr.push_back(8'hDF);
    haltRunCheck();

    startTest("loadStore");
    for (int i = 0; i < 40; i++)
      hostWrite(1'b0, 8'(8'hF0 + i), $urandom);   // Spans the wrap to 0x17
    prog.push_back(immInstr(AL, 1, 16'h12F8, 1'b0)); // Upper bits ignored
    for (int k = 2; k < 12; k++)
      prog.push_back(regInstr(AL, OP_LDR, 1'b0, k, 0, 1, 5'($urandom)));
    storeAllRegs(8'h80);
    haltRunCheck();

    startTest("backPressure");
    prog.push_back(immInstr(AL, 2, 16'($urandom), 1'b0));
    prog.push_back(immInstr(AL, 15, 16'h00E0, 1'b0));
    for (int i = 0; i < 20; i++)
      prog.push_back(immInstr(AL, 3 + i % 10, 16'($urandom), 1'b0));  // Keeps CPU busy
    prog.push_back(regInstr(AL, OP_STR, 1'b0, 0, 2, 15, 5));
    prog.push_back(regInstr(AL, OP_HALT, 1'b0, 0, 0, 0, 0));
    loadProgram();
    fork
      runProgram();
      begin
        repeat (4) @(posedge Clk);
        hostRead(1'b0, 8'hE5, mData[8'hE5]);
      end
    join
    repeat (5) @(posedge Clk);   // Halt must hold with no run pulse
    foreach (prog[i])
      modelStep(prog[i]);
    runProgram();
    hostRead(1'b0, 8'hE5, mData[8'hE5]);
    finishTest();

    $display("Summary: %0d tests, %0d read checks, %0d errors", testCount, checkCount, errCount);
    if (errCount == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: masterCpu.f
common/cpuPkg.sv
alu/masterAlu.sv
design/registerBank.sv
design/wordRam.sv
memctrl/memoryControl.sv
design/controlUnit.sv
design/masterCpu.sv
dv/tbMasterCpu.sv
